//--- src/opx_pkg.sv
// Operand stage shared definitions
// Widths, operand select codes, ALU opcodes and the instruction word
package opx_pkg;

	// Datapath and register file widths
	localparam int data_width     = 32;
	localparam int reg_addr_width = 5;
	localparam int imm_width      = 16;
	localparam int shamt_width    = $clog2(data_width);

	// Operand select codes
	localparam int sel_width = 2;
	localparam logic [sel_width-1:0] sel_rf      = 2'd0;
	localparam logic [sel_width-1:0] sel_imm     = 2'd1;
	localparam logic [sel_width-1:0] sel_ex_forw = 2'd2;
	localparam logic [sel_width-1:0] sel_wb_forw = 2'd3;

	// ALU opcodes, bit 3 set marks the immediate forms
	localparam int op_width = 4;
	localparam logic [op_width-1:0] op_add  = 4'h0;
	localparam logic [op_width-1:0] op_sub  = 4'h1;
	localparam logic [op_width-1:0] op_and  = 4'h2;
	localparam logic [op_width-1:0] op_or   = 4'h3;
	localparam logic [op_width-1:0] op_xor  = 4'h4;
	localparam logic [op_width-1:0] op_sll  = 4'h5;
	localparam logic [op_width-1:0] op_srl  = 4'h6;
	localparam logic [op_width-1:0] op_addi = 4'h8;
	localparam logic [op_width-1:0] op_andi = 4'h9;
	localparam logic [op_width-1:0] op_ori  = 4'ha;

	// Instruction word, register form or immediate form
	typedef union packed {
		struct packed {
			logic [op_width-1:0]       opcode;
			logic [reg_addr_width-1:0] rd;
			logic [reg_addr_width-1:0] ra;
			logic [reg_addr_width-1:0] rb;
			logic [12:0]               unused;
		} r;
		struct packed {
			logic [op_width-1:0]       opcode;
			logic [reg_addr_width-1:0] rd;
			logic [reg_addr_width-1:0] ra;
			logic [1:0]                pad;
			logic [imm_width-1:0]      imm;
		} i;
	} instr_u;

	// True for opcodes taking operand B from the immediate
	function automatic logic op_uses_imm(input logic [op_width-1:0] op);
		return (op == op_addi) || (op == op_andi) || (op == op_ori);
	endfunction

endpackage

//--- src/reg_file.sv
// General purpose register file
// 32 entries, two combinational read ports, one synchronous write port
// Register 0 is hardwired to zero on both read ports
`timescale 1ns/100ps

module reg_file (
	input  logic                               clk,
	input  logic                               reset,
	input  logic [opx_pkg::reg_addr_width-1:0] raddr_a,
	input  logic [opx_pkg::reg_addr_width-1:0] raddr_b,
	output logic [opx_pkg::data_width-1:0]     rdata_a,
	output logic [opx_pkg::data_width-1:0]     rdata_b,
	input  logic                               we,
	input  logic [opx_pkg::reg_addr_width-1:0] waddr,
	input  logic [opx_pkg::data_width-1:0]     wdata
);

	import opx_pkg::*;

	localparam int num_regs = 1 << reg_addr_width;

	// Register storage
	logic [data_width-1:0] regs [num_regs];

	////////////////////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////////////////////

	// Whole array cleared on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////////////////////

	// No bypass here, a write shows up the cycle after
	// Forwarding covers the same-cycle case
	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

//--- src/forward_ctrl.sv
// Operand forwarding controller
// Compares the decode source registers with the execute and writeback
// destinations and picks a source for each operand
`timescale 1ns/100ps

module forward_ctrl (
	input  logic                               use_imm,
	input  logic [opx_pkg::reg_addr_width-1:0] ra,
	input  logic [opx_pkg::reg_addr_width-1:0] rb,
	input  logic                               ex_valid,
	input  logic [opx_pkg::reg_addr_width-1:0] ex_dest,
	input  logic                               wb_valid,
	input  logic [opx_pkg::reg_addr_width-1:0] wb_dest,
	output logic [opx_pkg::sel_width-1:0]      sel_a,
	output logic [opx_pkg::sel_width-1:0]      sel_b
);

	import opx_pkg::*;

	// Stage holds a result that may be forwarded
	logic ex_live;
	logic wb_live;

	// Address matches per operand
	logic ex_hit_a;
	logic ex_hit_b;
	logic wb_hit_a;
	logic wb_hit_b;

	// Register 0 never forwards, it always reads zero
	assign ex_live = ex_valid && (ex_dest != '0);
	assign wb_live = wb_valid && (wb_dest != '0);

	assign ex_hit_a = ex_live && (ex_dest == ra);
	assign ex_hit_b = ex_live && (ex_dest == rb);
	assign wb_hit_a = wb_live && (wb_dest == ra);
	assign wb_hit_b = wb_live && (wb_dest == rb);

	////////////////////////////////////////////////////////////////////////////
	// Select priority
	////////////////////////////////////////////////////////////////////////////

	// Operand A: execute, then writeback, then register file
	// Execute holds the younger result so it wins
	always_comb begin
		if (ex_hit_a) begin
			sel_a = sel_ex_forw;
		end else if (wb_hit_a) begin
			sel_a = sel_wb_forw;
		end else begin
			sel_a = sel_rf;
		end
	end

	// Operand B: immediate first, rb is not a source then
	always_comb begin
		if (use_imm) begin
			sel_b = sel_imm;
		end else if (ex_hit_b) begin
			sel_b = sel_ex_forw;
		end else if (wb_hit_b) begin
			sel_b = sel_wb_forw;
		end else begin
			sel_b = sel_rf;
		end
	end

endmodule

//--- src/operand_muxes.sv
// Operand select muxes and execute stage operand registers
// Each operand picks register file, forwarded result or immediate,
// then registers into execute with a saved flag during decode stalls
`timescale 1ns/100ps

module operand_muxes (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          id_freeze,
	input  logic                          ex_freeze,
	input  logic [opx_pkg::data_width-1:0] rf_dataa,
	input  logic [opx_pkg::data_width-1:0] rf_datab,
	input  logic [opx_pkg::data_width-1:0] ex_forw,
	input  logic [opx_pkg::data_width-1:0] wb_forw,
	input  logic [opx_pkg::data_width-1:0] simm,
	input  logic [opx_pkg::sel_width-1:0]  sel_a,
	input  logic [opx_pkg::sel_width-1:0]  sel_b,
	output logic [opx_pkg::data_width-1:0] operand_a,
	output logic [opx_pkg::data_width-1:0] operand_b,
	output logic [opx_pkg::data_width-1:0] muxed_a,
	output logic [opx_pkg::data_width-1:0] muxed_b
);

	import opx_pkg::*;

	// Index 0 is operand A, index 1 is operand B
	logic [1:0][data_width-1:0] muxed_v;
	logic [1:0][data_width-1:0] operand_q;
	logic [1:0]                 saved;

	////////////////////////////////////////////////////////////////////////////
	// Forwarding muxes
	////////////////////////////////////////////////////////////////////////////

	// Operand A has no immediate leg
	always_comb begin
		case (sel_a)
			sel_ex_forw: muxed_a = ex_forw;
			sel_wb_forw: muxed_a = wb_forw;
			default:     muxed_a = rf_dataa;
		endcase
	end

	always_comb begin
		case (sel_b)
			sel_imm:     muxed_b = simm;
			sel_ex_forw: muxed_b = ex_forw;
			sel_wb_forw: muxed_b = wb_forw;
			default:     muxed_b = rf_datab;
		endcase
	end

	assign muxed_v = {muxed_b, muxed_a};

	////////////////////////////////////////////////////////////////////////////
	// Operand registers
	////////////////////////////////////////////////////////////////////////////

	// Execute frozen: hold everything
	// Decode stalled: capture once, then keep the captured value
	// Both running: load every edge and drop the saved flag
	always_ff @(posedge clk) begin
		if (reset) begin
			operand_q <= '0;
			saved     <= '0;
		end else if (!ex_freeze) begin
			for (int i = 0; i < 2; i++) begin
				if (!id_freeze) begin
					operand_q[i] <= muxed_v[i];
					saved[i]     <= 1'b0;
				end else if (!saved[i]) begin
					operand_q[i] <= muxed_v[i];
					saved[i]     <= 1'b1;
				end
			end
		end
	end

	assign operand_a = operand_q[0];
	assign operand_b = operand_q[1];

endmodule

//--- src/exec_alu.sv
// Execute stage and writeback result register
// Tracks the instruction in execute, computes the ALU result and
// holds it in the result register until the consumer takes it
`timescale 1ns/100ps

module exec_alu (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               ex_freeze,
	input  logic                               issue,
	input  logic [opx_pkg::op_width-1:0]       opcode,
	input  logic [opx_pkg::reg_addr_width-1:0] dest,
	input  logic [opx_pkg::data_width-1:0]     operand_a,
	input  logic [opx_pkg::data_width-1:0]     operand_b,
	output logic                               ex_valid,
	output logic [opx_pkg::reg_addr_width-1:0] ex_dest,
	output logic [opx_pkg::data_width-1:0]     ex_result,
	output logic                               wb_valid,
	output logic [opx_pkg::reg_addr_width-1:0] wb_dest,
	output logic [opx_pkg::data_width-1:0]     wb_data,
	input  logic                               res_ready
);

	import opx_pkg::*;

	logic [op_width-1:0]    ex_opcode;
	logic [shamt_width-1:0] shamt;

	////////////////////////////////////////////////////////////////////////////
	// Execute stage control
	////////////////////////////////////////////////////////////////////////////

	// Loads alongside the operand registers
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_valid <= 1'b0;
		end else if (!ex_freeze) begin
			ex_valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			ex_opcode <= opcode;
			ex_dest   <= dest;
		end
	end

	// ALU result doubles as the execute forwarding source
	assign shamt = operand_b[shamt_width-1:0];

	always_comb begin
		case (ex_opcode)
			op_add, op_addi: ex_result = operand_a + operand_b;
			op_sub:          ex_result = operand_a - operand_b;
			op_and, op_andi: ex_result = operand_a & operand_b;
			op_or, op_ori:   ex_result = operand_a | operand_b;
			op_xor:          ex_result = operand_a ^ operand_b;
			op_sll:          ex_result = operand_a << shamt;
			op_srl:          ex_result = operand_a >> shamt;
			default:         ex_result = '0;
		endcase
	end

	// Result register
	// Set when execute advances a result into it
	// Cleared by the handshake when execute has nothing to refill it
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else if (ex_valid && !ex_freeze) begin
			wb_valid <= 1'b1;
		end else if (res_ready) begin
			wb_valid <= 1'b0;
		end
	end

	// Payload stays put until the handshake
	always_ff @(posedge clk) begin
		if (!ex_freeze && ex_valid) begin
			wb_data <= ex_result;
			wb_dest <= ex_dest;
		end
	end

endmodule

//--- src/freeze_ctrl.sv
// Pipeline freeze control
// Execute stalls on a blocked result, decode stalls when no
// instruction is taken this cycle
`timescale 1ns/100ps

module freeze_ctrl (
	input  logic instr_valid,
	input  logic wb_valid,
	input  logic res_ready,
	output logic id_freeze,
	output logic ex_freeze,
	output logic instr_ready,
	output logic issue
);

	////////////////////////////////////////////////////////////////////////////
	// Stall decisions
	////////////////////////////////////////////////////////////////////////////

	// Result register full and not drained, everything behind it waits
	assign ex_freeze = wb_valid && !res_ready;

	// Decode can only move when execute moves
	assign instr_ready = !ex_freeze;

	// Accepted instruction, enters execute at this edge
	assign issue = instr_valid && instr_ready;

	// No handshake means no new instruction for execute
	// Covers both an empty port and a frozen execute stage
	assign id_freeze = !issue;

endmodule

//--- src/int_pipe_top.sv
// Integer pipeline operand stage top level
// Decode reads the register file, forwarding picks the operands,
// execute computes and the result register drives the result port
`timescale 1ns/100ps

module int_pipe_top (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               instr_valid,
	output logic                               instr_ready,
	input  opx_pkg::instr_u                    instr,
	output logic                               res_valid,
	input  logic                               res_ready,
	output logic [opx_pkg::data_width-1:0]     res_data,
	output logic [opx_pkg::reg_addr_width-1:0] res_dest
);

	import opx_pkg::*;

	// Decode
	logic                      use_imm;
	logic [data_width-1:0]     simm;
	logic [data_width-1:0]     rf_dataa;
	logic [data_width-1:0]     rf_datab;
	logic                      rf_we;
	logic [sel_width-1:0]      sel_a;
	logic [sel_width-1:0]      sel_b;

	// Execute
	logic [data_width-1:0]     operand_a;
	logic [data_width-1:0]     operand_b;
	logic                      ex_valid;
	logic [reg_addr_width-1:0] ex_dest;
	logic [data_width-1:0]     ex_result;

	// Stall control
	logic                      id_freeze;
	logic                      ex_freeze;
	logic                      issue;

	assign simm    = {{(data_width-imm_width){instr.i.imm[imm_width-1]}}, instr.i.imm};
	assign use_imm = op_uses_imm(instr.r.opcode);

	// Writeback on the result handshake
	assign rf_we = res_valid && res_ready;

	reg_file i_reg_file (
		.clk(clk), .reset(reset),
		.raddr_a(instr.r.ra), .raddr_b(instr.r.rb),
		.rdata_a(rf_dataa), .rdata_b(rf_datab),
		.we(rf_we), .waddr(res_dest), .wdata(res_data)
	);

	forward_ctrl i_forward_ctrl (
		.use_imm(use_imm), .ra(instr.r.ra), .rb(instr.r.rb),
		.ex_valid(ex_valid), .ex_dest(ex_dest),
		.wb_valid(res_valid), .wb_dest(res_dest),
		.sel_a(sel_a), .sel_b(sel_b)
	);

	operand_muxes i_operand_muxes (
		.clk(clk), .reset(reset), .id_freeze(id_freeze), .ex_freeze(ex_freeze),
		.rf_dataa(rf_dataa), .rf_datab(rf_datab),
		.ex_forw(ex_result), .wb_forw(res_data), .simm(simm),
		.sel_a(sel_a), .sel_b(sel_b),
		.operand_a(operand_a), .operand_b(operand_b),
		.muxed_a(), .muxed_b()
	);

	exec_alu i_exec_alu (
		.clk(clk), .reset(reset), .ex_freeze(ex_freeze), .issue(issue),
		.opcode(instr.r.opcode), .dest(instr.r.rd),
		.operand_a(operand_a), .operand_b(operand_b),
		.ex_valid(ex_valid), .ex_dest(ex_dest), .ex_result(ex_result),
		.wb_valid(res_valid), .wb_dest(res_dest), .wb_data(res_data),
		.res_ready(res_ready)
	);

	freeze_ctrl i_freeze_ctrl (
		.instr_valid(instr_valid), .wb_valid(res_valid), .res_ready(res_ready),
		.id_freeze(id_freeze), .ex_freeze(ex_freeze),
		.instr_ready(instr_ready), .issue(issue)
	);

endmodule

//--- verif/tb_clk_gen.sv
// Testbench clock and reset source
// 10 ns clock and a reset held high for the first 8 rising edges
`timescale 1ns/100ps

module tb_clk_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- verif/int_pipe_tb.sv
// Integer pipeline operand stage testbench
// Register file reference model and an expected result queue,
// checked by assertions on every result handshake
`timescale 1ns/100ps

module int_pipe_tb;

	import opx_pkg::*;

	// Opcode pool with the 7 register forms first
	localparam logic [op_width-1:0] op_list [10] = '{
		op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_addi, op_andi, op_ori
	};

	logic                      clk;
	logic                      reset;
	logic                      instr_valid = 1'b0;
	logic                      instr_ready;
	instr_u                    instr = '0;
	logic                      res_valid;
	logic                      res_ready = 1'b0;
	logic [data_width-1:0]     res_data;
	logic [reg_addr_width-1:0] res_dest;

	// Result consumer mode selects always ready (0), random (1) or held low (2)
	logic [1:0] ready_mode = 2'd0;

	// Reference register file and results still owed by the DUT
	logic [data_width-1:0]     mregs [32];
	logic [data_width-1:0]     exp_data_q [$];
	logic [reg_addr_width-1:0] exp_dest_q [$];

	int issued;
	int checked;
	int errors;
	int seq_errors;
	int cycles;
	int chk_mark;
	int err_mark;
	int total;

	tb_clk_gen i_tb_clk_gen (.clk(clk), .reset(reset));

	int_pipe_top i_int_pipe_top (
		.clk(clk), .reset(reset),
		.instr_valid(instr_valid), .instr_ready(instr_ready), .instr(instr),
		.res_valid(res_valid), .res_ready(res_ready),
		.res_data(res_data), .res_dest(res_dest)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic is_imm_op(input logic [op_width-1:0] op);
		return (op == op_addi) || (op == op_andi) || (op == op_ori);
	endfunction

	// Instruction semantics with shifts by the low 5 bits of B
	function automatic logic [data_width-1:0] alu_ref(input logic [op_width-1:0] op,
			input logic [data_width-1:0] a, input logic [data_width-1:0] b);
		case (op)
			op_add, op_addi: return a + b;
			op_sub:          return a - b;
			op_and, op_andi: return a & b;
			op_or, op_ori:   return a | b;
			op_xor:          return a ^ b;
			op_sll:          return a << b[4:0];
			op_srl:          return a >> b[4:0];
			default:         return '0;
		endcase
	endfunction

	// Immediate forms leave rb out and register forms leave imm out
	function automatic instr_u make_instr(input logic [op_width-1:0] op,
			input logic [4:0] rd, input logic [4:0] ra, input logic [4:0] rb,
			input logic [15:0] imm);
		instr_u w;
		w = '0;
		w.r.opcode = op;
		w.r.rd = rd;
		w.r.ra = ra;
		if (is_imm_op(op)) begin
			w.i.imm = imm;
		end else begin
			w.r.rb = rb;
		end
		return w;
	endfunction

	function automatic logic [op_width-1:0] random_opcode(input int span);
		return op_list[4'($urandom % span)];
	endfunction

	// Model runs in issue order, so its registers are what decode must see
	task automatic accept_instr();
		logic [data_width-1:0] a;
		logic [data_width-1:0] b;
		logic [data_width-1:0] r;
		a = mregs[instr.r.ra];
		if (is_imm_op(instr.r.opcode)) begin
			b = {{16{instr.i.imm[15]}}, instr.i.imm};
		end else begin
			b = mregs[instr.r.rb];
		end
		r = alu_ref(instr.r.opcode, a, b);
		exp_data_q.push_back(r);
		exp_dest_q.push_back(instr.r.rd);
		if (instr.r.rd != 5'd0) begin
			mregs[instr.r.rd] = r;
		end
		issued++;
	endtask

	task automatic check_result();
		logic [data_width-1:0]     exp_data;
		logic [reg_addr_width-1:0] exp_dest;
		assert (exp_data_q.size() != 0) else begin
			$display("Time %0t: result delivered with no instruction outstanding", $time);
			errors++;
		end
		if (exp_data_q.size() != 0) begin
			exp_data = exp_data_q.pop_front();
			exp_dest = exp_dest_q.pop_front();
			checked++;
			assert (res_dest == exp_dest) else begin
				$display("[FAIL] time %0t res_dest got %0d expected %0d",
					$time, res_dest, exp_dest);
				errors++;
			end
			assert (res_data == exp_data) else begin
				$display("[FAIL] time %0t res_data got %h expected %h",
					$time, res_data, exp_data);
				errors++;
			end
		end
	endtask

	// Handshakes sampled on the edge before any drive lands
	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				mregs[i] = '0;
			end
		end else begin
			// A blocked result must hold the instruction port
			assert (!(res_valid && !res_ready) || !instr_ready) else begin
				$display("Time %0t: instr_ready high while the result is blocked", $time);
				errors++;
			end
			if (res_valid && res_ready) begin
				check_result();
			end
			if (instr_valid && instr_ready) begin
				accept_instr();
			end
		end
	end

	always @(posedge clk) begin
		case (ready_mode)
			2'd1:    res_ready <= 1'($urandom);
			2'd2:    res_ready <= 1'b0;
			default: res_ready <= 1'b1;
		endcase
	end

	// Limit grows with the work issued so far
	always @(posedge clk) begin
		cycles++;
		if (cycles > 20 * issued + 100) begin
			$display("Timeout after %0d cycles with %0d instructions issued", cycles, issued);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	// Held until accepted and returns on the handshake edge
	task automatic send(input instr_u w);
		instr_valid <= 1'b1;
		instr <= w;
		@(posedge clk);
		while (!instr_ready) begin
			@(posedge clk);
		end
		instr_valid <= 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
	endtask

	// Queue polled on the falling edge once the rising edge updates have settled
	task automatic drain();
		do begin
			@(negedge clk);
		end while (exp_data_q.size() != 0);
		@(posedge clk);
	endtask

	task automatic report(input string name);
		$display("Test %s: %0d results checked, %0d errors", name,
			checked - chk_mark, errors + seq_errors - err_mark);
		chk_mark = checked;
		err_mark = errors + seq_errors;
	endtask

	initial begin
		logic [4:0] dst;
		logic [4:0] src;
		void'($urandom(32'h254a));
		@(posedge clk);
		while (reset) begin
			@(posedge clk);
		end

		// Test 1 checks the reset state then reads never written registers
		assert (res_valid == 1'b0) else begin
			$display("[FAIL] time %0t res_valid got %0b expected 0", $time, res_valid);
			seq_errors++;
		end
		assert (instr_ready == 1'b1) else begin
			$display("[FAIL] time %0t instr_ready got %0b expected 1", $time, instr_ready);
			seq_errors++;
		end
		send(make_instr(op_add, 5'd5, 5'd3, 5'd7, '0));
		drain();
		report("1 reset state");

		// Test 2 seeds r1..r7 then runs a random mix over r0..r7
		for (int r = 1; r < 8; r++) begin
			send(make_instr(op_addi, 5'(r), 5'd0, 5'd0, 16'($urandom)));
		end
		for (int k = 0; k < 40; k++) begin
			send(make_instr(random_opcode(10), 5'($urandom % 8), 5'($urandom % 8),
				5'($urandom % 8), 16'($urandom)));
			idle($urandom % 3);
		end
		drain();
		report("2 random instructions");

		// Test 3 has each instruction read the one just before it
		for (int k = 0; k < 24; k++) begin
			dst = 5'(10 + k % 3);
			src = 5'(10 + (k + 2) % 3);
			send(make_instr(random_opcode(10), dst, src, src, 16'($urandom)));
		end
		drain();
		report("3 execute forwarding");

		// Test 4 uses a one cycle gap for writeback and two cycles for the register file
		for (int k = 0; k < 12; k++) begin
			send(make_instr(random_opcode(10), 5'd20, 5'($urandom % 8),
				5'($urandom % 8), 16'($urandom)));
			idle(1 + k % 2);
			send(make_instr(random_opcode(7), 5'd21, 5'd20, 5'd20, '0));
		end
		drain();
		report("4 writeback forwarding");

		// Test 5 puts random back-pressure on the result port
		ready_mode <= 2'd1;
		for (int k = 0; k < 40; k++) begin
			send(make_instr(random_opcode(10), 5'($urandom % 8), 5'($urandom % 8),
				5'($urandom % 8), 16'($urandom)));
			idle($urandom % 2);
		end
		drain();
		ready_mode <= 2'd0;
		idle(3);
		assert (res_valid == 1'b0) else begin
			$display("[FAIL] time %0t res_valid got %0b expected 0", $time, res_valid);
			seq_errors++;
		end
		report("5 result back-pressure");

		// Test 6 freezes B in execute while C waits on it
		for (int k = 0; k < 8; k++) begin
			ready_mode <= 2'd2;
			send(make_instr(op_addi, 5'd24, 5'd0, 5'd0, 16'($urandom)));
			send(make_instr(random_opcode(7), 5'd25, 5'd24, 5'd24, '0));
			fork
				send(make_instr(random_opcode(7), 5'd26, 5'd25, 5'd24, '0));
				begin
					idle(4);
					ready_mode <= 2'd0;
				end
			join
			drain();
		end
		report("6 stalled producer");

		total = errors + seq_errors;
		$display("Summary: %0d instructions, %0d results checked, %0d errors",
			issued, checked, total);
		if (total == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- flist.f
src/opx_pkg.sv
src/reg_file.sv
src/forward_ctrl.sv
src/operand_muxes.sv
src/exec_alu.sv
src/freeze_ctrl.sv
src/int_pipe_top.sv
verif/tb_clk_gen.sv
verif/int_pipe_tb.sv

//--- Makefile
# Verilator build and run for the integer pipeline operand stage

TOP := int_pipe_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -Mdir obj_dir -f flist.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
